//--- rtl/video_pkg.sv
`default_nettype none

package video_pkg;

    localparam int X_BITS = 11; // Covers 1280 active pixels.
    localparam int Y_BITS = 10; // Covers 720 active lines.

    // Camera pixel, blue on top and red on the bottom as the sensor packs it.
    typedef struct packed {
        logic [4:0] b;
        logic [5:0] g;
        logic [4:0] r;
    } rgb565_t;

    typedef struct packed {
        logic              hsync;
        logic              vsync;
        logic              de;
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
    } video_timing_t;

    typedef struct packed {
        logic              hsync;
        logic              vsync;
        logic              de;
        logic [7:0]        r;
        logic [7:0]        g;
        logic [7:0]        b;
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
    } video_out_t;

endpackage : video_pkg

`default_nettype wire

//--- rtl/video_timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing_gen
    import video_pkg::*;
#(
    parameter int H_SYNC = 12,
    parameter int H_BP   = 300,
    parameter int H_ACT  = 1280,
    parameter int H_FP   = 300,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 9,
    parameter int V_ACT  = 720,
    parameter int V_FP   = 9
) (
    input  wire logic          disp_clk,
    input  wire logic          rstn,
    input  wire logic          i_run,
    output video_timing_t      o_timing,
    output logic               o_rd_en
);

    localparam int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP;
    localparam int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP;
    localparam int HC_BITS = $clog2(H_TOTAL);
    localparam int VC_BITS = $clog2(V_TOTAL);

    localparam logic [HC_BITS-1:0] H_SYNC_END = HC_BITS'(H_SYNC);
    localparam logic [HC_BITS-1:0] H_START    = HC_BITS'(H_SYNC + H_BP);
    localparam logic [HC_BITS-1:0] H_END      = HC_BITS'(H_SYNC + H_BP + H_ACT);
    localparam logic [HC_BITS-1:0] H_LAST     = HC_BITS'(H_TOTAL - 1);
    localparam logic [VC_BITS-1:0] V_SYNC_END = VC_BITS'(V_SYNC);
    localparam logic [VC_BITS-1:0] V_START    = VC_BITS'(V_SYNC + V_BP);
    localparam logic [VC_BITS-1:0] V_END      = VC_BITS'(V_SYNC + V_BP + V_ACT);
    localparam logic [VC_BITS-1:0] V_LAST     = VC_BITS'(V_TOTAL - 1);

    logic [HC_BITS-1:0] h_cnt;
    logic [VC_BITS-1:0] v_cnt;
    logic               h_act;
    logic               v_act;
    video_timing_t      timing_d;
    video_timing_t      timing_early;

    always_ff @(posedge disp_clk or negedge rstn) begin
        if (!rstn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!i_run) begin
            h_cnt <= '0; // Parked on the first hsync cycle of line 0.
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_act = (h_cnt >= H_START) && (h_cnt < H_END);
    assign v_act = (v_cnt >= V_START) && (v_cnt < V_END);

    always_comb begin
        timing_d       = '0;
        timing_d.hsync = (h_cnt < H_SYNC_END);
        timing_d.vsync = (v_cnt < V_SYNC_END);
        timing_d.de    = h_act && v_act;
        if (h_act && v_act) begin
            timing_d.x = X_BITS'(h_cnt - H_START);
            timing_d.y = Y_BITS'(v_cnt - V_START);
        end
    end

    // The early stage drives the FIFO read, the late stage meets the read data.
    always_ff @(posedge disp_clk or negedge rstn) begin
        if (!rstn) begin
            timing_early <= '0;
            o_timing     <= '0;
        end else begin
            timing_early <= i_run ? timing_d : '0;
            o_timing     <= timing_early;
        end
    end

    assign o_rd_en = timing_early.de;

    a_de_in_active: assert property (@(posedge disp_clk) disable iff (!rstn)
        o_timing.de |-> (o_timing.x < H_ACT) && (o_timing.y < V_ACT));

endmodule : video_timing_gen

`default_nettype wire

//--- rtl/cam_pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cam_pixel_fifo
    import video_pkg::*;
#(
    parameter int ADDR_BITS = 11
) (
    input  wire logic    cam_clk,
    input  wire logic    disp_clk,
    input  wire logic    rstn,
    input  wire logic    i_vsync,
    input  wire logic    i_href,
    input  wire rgb565_t i_data,
    input  wire logic    i_rd_en,
    output rgb565_t      o_pixel,
    output logic         o_frame_started,
    output logic         o_underflow
);

    localparam int DEPTH = 1 << ADDR_BITS;

    rgb565_t mem [DEPTH];

    logic               vsync_d;
    logic               started_cam;
    logic [1:0]         started_sync;
    logic               wr_en;
    logic               full;
    logic               empty;

    logic [ADDR_BITS:0] wr_bin;
    logic [ADDR_BITS:0] wr_gray;
    logic [ADDR_BITS:0] wr_bin_next;
    logic [ADDR_BITS:0] rd_bin;
    logic [ADDR_BITS:0] rd_gray;
    logic [ADDR_BITS:0] rd_bin_next;

    logic [ADDR_BITS:0] rd_gray_q1;
    logic [ADDR_BITS:0] rd_gray_q2;
    logic [ADDR_BITS:0] wr_gray_q1;
    logic [ADDR_BITS:0] wr_gray_q2;

    // Frame start detector in the camera domain.
    always_ff @(posedge cam_clk or negedge rstn) begin
        if (!rstn) begin
            vsync_d     <= 1'b0;
            started_cam <= 1'b0;
        end else begin
            vsync_d <= i_vsync;
            if (!vsync_d && i_vsync) begin
                started_cam <= 1'b1; // Stays set until the next reset.
            end
        end
    end

    assign wr_en       = i_href && started_cam; // Drops the partial first frame.
    assign wr_bin_next = wr_bin + 1'b1;

    always_ff @(posedge cam_clk or negedge rstn) begin
        if (!rstn) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (wr_en) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
        end
    end

    always_ff @(posedge cam_clk) begin
        if (wr_en) begin
            mem[wr_bin[ADDR_BITS-1:0]] <= i_data;
        end
    end

    always_ff @(posedge cam_clk or negedge rstn) begin
        if (!rstn) begin
            rd_gray_q1 <= '0;
            rd_gray_q2 <= '0;
        end else begin
            rd_gray_q1 <= rd_gray;
            rd_gray_q2 <= rd_gray_q1;
        end
    end

    // Full when the pointers differ only in the wrap bit, which in Gray code is the top two.
    assign full = (wr_gray == {~rd_gray_q2[ADDR_BITS -: 2], rd_gray_q2[ADDR_BITS-2:0]});

    always_ff @(posedge disp_clk or negedge rstn) begin
        if (!rstn) begin
            wr_gray_q1   <= '0;
            wr_gray_q2   <= '0;
            started_sync <= '0;
        end else begin
            wr_gray_q1   <= wr_gray;
            wr_gray_q2   <= wr_gray_q1;
            started_sync <= {started_sync[0], started_cam};
        end
    end

    assign o_frame_started = started_sync[1];
    assign empty           = (rd_gray == wr_gray_q2);
    assign rd_bin_next     = rd_bin + 1'b1;

    always_ff @(posedge disp_clk or negedge rstn) begin
        if (!rstn) begin
            rd_bin      <= '0;
            rd_gray     <= '0;
            o_underflow <= 1'b0;
        end else if (i_rd_en) begin
            if (empty) begin
                o_underflow <= 1'b1;
            end else begin
                rd_bin  <= rd_bin_next;
                rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
            end
        end
    end

    // On an empty read the last word simply stays on the output.
    always_ff @(posedge disp_clk) begin
        if (i_rd_en && !empty) begin
            o_pixel <= mem[rd_bin[ADDR_BITS-1:0]];
        end
    end

    a_no_write_full: assert property (@(posedge cam_clk) disable iff (!rstn)
        wr_en |-> !full);

endmodule : cam_pixel_fifo

`default_nettype wire

//--- rtl/rgb_output_pack.sv
`timescale 1ns/1ps
`default_nettype none

module rgb_output_pack
    import video_pkg::*;
(
    input  wire logic          disp_clk,
    input  wire logic          rstn,
    input  wire video_timing_t i_timing,
    input  wire rgb565_t       i_pixel,
    output video_out_t         o_pack
);

    video_out_t pack_d;

    always_comb begin
        pack_d       = '0;
        pack_d.hsync = i_timing.hsync;
        pack_d.vsync = i_timing.vsync;
        pack_d.de    = i_timing.de;
        pack_d.x     = i_timing.x;
        pack_d.y     = i_timing.y;
        // The pixel register holds stale data in blanking, so colour is masked by de.
        if (i_timing.de) begin
            pack_d.r = {i_pixel.r, 3'b000};
            pack_d.g = {i_pixel.g, 2'b00};
            pack_d.b = {i_pixel.b, 3'b000};
        end
    end

    always_ff @(posedge disp_clk or negedge rstn) begin
        if (!rstn) begin
            o_pack <= '0;
        end else begin
            o_pack <= pack_d; // Sync, colour and coordinates leave in the same cycle.
        end
    end

endmodule : rgb_output_pack

`default_nettype wire

//--- rtl/hdmi_display.sv
`timescale 1ns/1ps
`default_nettype none

module hdmi_display
    import video_pkg::*;
#(
    parameter int H_SYNC    = 12,
    parameter int H_BP      = 300,
    parameter int H_ACT     = 1280,
    parameter int H_FP      = 300,
    parameter int V_SYNC    = 2,
    parameter int V_BP      = 9,
    parameter int V_ACT     = 720,
    parameter int V_FP      = 9,
    parameter int ADDR_BITS = 11
) (
    input  wire logic    cam_clk,
    input  wire logic    disp_clk,
    input  wire logic    rstn,
    input  wire logic    i_vsync,
    input  wire logic    i_href,
    input  wire rgb565_t i_data,
    output video_out_t   o_pack,
    output logic         o_underflow
);

    logic          frame_started;
    logic          rd_en;
    video_timing_t timing;
    rgb565_t       pixel;

    cam_pixel_fifo #(
        .ADDR_BITS(ADDR_BITS)
    ) u_cam_pixel_fifo (
        .cam_clk        (cam_clk      ),
        .disp_clk       (disp_clk     ),
        .rstn           (rstn         ),
        .i_vsync        (i_vsync      ),
        .i_href         (i_href       ),
        .i_data         (i_data       ),
        .i_rd_en        (rd_en        ),
        .o_pixel        (pixel        ),
        .o_frame_started(frame_started),
        .o_underflow    (o_underflow  )
    );

    // Display timing idles until the camera has started its first frame.
    video_timing_gen #(
        .H_SYNC(H_SYNC),
        .H_BP  (H_BP  ),
        .H_ACT (H_ACT ),
        .H_FP  (H_FP  ),
        .V_SYNC(V_SYNC),
        .V_BP  (V_BP  ),
        .V_ACT (V_ACT ),
        .V_FP  (V_FP  )
    ) u_video_timing_gen (
        .disp_clk(disp_clk     ),
        .rstn    (rstn         ),
        .i_run   (frame_started),
        .o_timing(timing       ),
        .o_rd_en (rd_en        )
    );

    rgb_output_pack u_rgb_output_pack (
        .disp_clk(disp_clk),
        .rstn    (rstn    ),
        .i_timing(timing  ),
        .i_pixel (pixel   ),
        .o_pack  (o_pack  )
    );

endmodule : hdmi_display

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100,
    parameter int PHASE_NS  = 0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        if (PHASE_NS > 0) begin
            #(PHASE_NS); // Shifts every edge of this clock by the offset.
        end
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule : tb_clock

`default_nettype wire

//--- sim/tb_hdmi_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hdmi_display
    import video_pkg::*;
();

    localparam int H_SYNC = 2;
    localparam int H_BP   = 3;
    localparam int H_ACT  = 8;
    localparam int H_FP   = 3;
    localparam int V_SYNC = 1;
    localparam int V_BP   = 1;
    localparam int V_ACT  = 4;
    localparam int V_FP   = 1;
    localparam int H_TOTAL        = H_SYNC + H_BP + H_ACT + H_FP;
    localparam int V_TOTAL        = V_SYNC + V_BP + V_ACT + V_FP;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int PIX_PER_FRAME  = H_ACT * V_ACT;
    localparam int SHORT_FRAME    = 20;
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 200;

    logic       cam_clk;
    logic       disp_clk;
    logic       rstn;
    logic       cam_vsync;
    logic       cam_href;
    rgb565_t    cam_data;
    video_out_t pack;
    logic       underflow;

    integer     seed;
    rgb565_t    pix_q[$]; // Pixels the camera has written, in order.
    rgb565_t    last_px;
    string      cur_test;
    int         err_count      = 0;
    int         test_err_start = 0;
    int         tests_passed   = 0;
    int         tests_failed   = 0;
    int         disp_cycles    = 0;
    int         cnt            = 0;
    int         de_in_frame    = 0;
    int         de_seen        = 0;
    int         hs_rises       = 0;
    logic       hs_prev        = 1'b0;
    logic       started        = 1'b0;

    tb_clock #(.PERIOD_NS(100), .PHASE_NS(0))  u_cam_clock  (.o_clk(cam_clk));
    tb_clock #(.PERIOD_NS(100), .PHASE_NS(30)) u_disp_clock (.o_clk(disp_clk));

    hdmi_display #(
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP  ),
        .H_ACT    (H_ACT ),
        .H_FP     (H_FP  ),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP  ),
        .V_ACT    (V_ACT ),
        .V_FP     (V_FP  ),
        .ADDR_BITS(6     )
    ) DUT (
        .cam_clk    (cam_clk  ),
        .disp_clk   (disp_clk ),
        .rstn       (rstn     ),
        .i_vsync    (cam_vsync),
        .i_href     (cam_href ),
        .i_data     (cam_data ),
        .o_pack     (pack     ),
        .o_underflow(underflow)
    );

    // RGB565 to 24 bits, each field zero padded in its low bits.
    function automatic logic [23:0] expand_pixel(input rgb565_t p);
        return {p.r, 3'b000, p.g, 2'b00, p.b, 3'b000};
    endfunction

    task automatic check_value(input string field, input logic [47:0] expected,
                               input logic [47:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %0h actual %0h", cur_test, field, expected, actual);
            err_count++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        int errs;
        errs = err_count - test_err_start;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s done, no errors", cur_test);
        end else begin
            tests_failed++;
            $display("test %s done, %0d errors", cur_test, errs);
        end
    endtask

    task automatic wait_cam();
        @(posedge cam_clk);
        #5;
    endtask

    // One camera frame lasts exactly one display frame, so both stay locked.
    task automatic send_frame(input int n_pix);
        int          cycles;
        int          sent;
        logic        last_gap;
        logic [15:0] raw;
        cycles   = 0;
        sent     = 0;
        last_gap = 1'b1;
        cam_vsync = 1'b1;
        repeat (2) begin
            wait_cam();
            cycles++;
        end
        cam_vsync = 1'b0;
        while (sent < n_pix) begin
            if (!last_gap && (($random(seed) & 1) == 1)) begin
                cam_href = 1'b0; // Idle gaps never run two cycles in a row.
                last_gap = 1'b1;
            end else begin
                raw      = $random(seed);
                cam_data = raw;
                cam_href = 1'b1;
                pix_q.push_back(cam_data);
                sent++;
                last_gap = 1'b0;
            end
            wait_cam();
            cycles++;
        end
        cam_href = 1'b0;
        cam_data = '0;
        while (cycles < FRAME_CYCLES) begin
            wait_cam();
            cycles++;
        end
    endtask

    task automatic finish_run();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        seed      = 32'ha168_a55d;
        rstn      = 1'b0;
        cam_vsync = 1'b0;
        cam_href  = 1'b0;
        cam_data  = '0;
        begin_test("reset_idle");
        repeat (4) @(posedge cam_clk);
        #5 rstn = 1'b1;
        repeat (8) wait_cam();
        for (int f = 0; f < 3; f++) begin
            send_frame(PIX_PER_FRAME);
        end
        send_frame(SHORT_FRAME); // Too short, so the display runs the FIFO dry.
    end

    // Outputs are sampled on the falling display edge, half a cycle after they move.
    always @(negedge disp_clk) begin
        int          c;
        int          line;
        int          h;
        int          f;
        logic        exp_de;
        logic [23:0] exp_rgb;
        if (!started && !pack.vsync) begin
            check_value("pack", '0, pack);
            check_value("underflow", '0, underflow);
        end else begin
            if (!started) begin
                started = 1'b1;
                end_test();
                begin_test("frame0_pixels");
            end
            f    = cnt / FRAME_CYCLES;
            c    = cnt % FRAME_CYCLES;
            line = c / H_TOTAL;
            h    = c % H_TOTAL;
            cnt++;
            exp_de = (line >= V_SYNC + V_BP) && (line < V_SYNC + V_BP + V_ACT) &&
                     (h >= H_SYNC + H_BP) && (h < H_SYNC + H_BP + H_ACT);
            check_value("hsync", h < H_SYNC, pack.hsync);
            check_value("vsync", line < V_SYNC, pack.vsync);
            check_value("de", exp_de, pack.de);
            check_value("x", exp_de ? h - (H_SYNC + H_BP) : 0, pack.x);
            check_value("y", exp_de ? line - (V_SYNC + V_BP) : 0, pack.y);
            if (pack.hsync && !hs_prev) begin
                hs_rises++;
            end
            hs_prev = pack.hsync;
            if (pack.de) begin
                de_seen++;
            end
            exp_rgb = '0;
            if (exp_de) begin
                if (f < 3 || de_in_frame < SHORT_FRAME) begin
                    if (pix_q.size() == 0) begin
                        $display("ERROR: %s has a de cycle but no camera pixel is queued",
                                 cur_test);
                        err_count++;
                    end else begin
                        last_px = pix_q.pop_front();
                    end
                end
                exp_rgb = expand_pixel(last_px); // After underflow the last word repeats.
                if (f == 3 && de_in_frame < SHORT_FRAME - 1) begin
                    check_value("underflow", 1'b0, underflow);
                end else if (f == 3 && de_in_frame >= SHORT_FRAME) begin
                    check_value("underflow", 1'b1, underflow);
                end
                de_in_frame++;
            end
            check_value("rgb", exp_rgb, {pack.r, pack.g, pack.b});
            if (f < 3) begin
                check_value("underflow", 1'b0, underflow);
            end
            if (c == FRAME_CYCLES - 1) begin
                check_value("de count", PIX_PER_FRAME, de_seen);
                check_value("line count", V_TOTAL, hs_rises);
                de_in_frame = 0;
                de_seen     = 0;
                hs_rises    = 0;
                if (f == 3) begin
                    check_value("underflow", 1'b1, underflow);
                    check_value("queue left", 0, pix_q.size());
                    end_test();
                    finish_run();
                end else begin
                    end_test();
                    if (f == 2) begin
                        begin_test("frame3_underflow");
                    end else begin
                        begin_test($sformatf("frame%0d_pixels", f + 1));
                    end
                end
            end
        end
    end

    always @(posedge disp_clk) begin
        disp_cycles++;
        if (disp_cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d display clock cycles",
                     TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule : tb_hdmi_display

`default_nettype wire

//--- cam_display.f
rtl/video_pkg.sv
rtl/video_timing_gen.sv
rtl/cam_pixel_fifo.sv
rtl/rgb_output_pack.sv
rtl/hdmi_display.sv
sim/tb_clock.sv
sim/tb_hdmi_display.sv
